// File: pong_top.f
logic/video_pkg.sv
logic/game_pkg.sv
logic/btn_debounce.sv
logic/raster_timing.sv
logic/paddle_ctrl.sv
logic/game_core.sv
logic/frame_render.sv
logic/pong_top.sv
tb/pong_tb.sv

// File: tb/pong_stimulus.txt
# action  frames  state (hex, 7 any)  left paddle row shown (hex, 3ff any)  score_l  score_r (f any)
# wait plays out the current point, match plays points until the game ends
rel     2    2  024  0  0
glitch  3    2  024  0  0
fire    1    3  024  0  0
up      5    3  018  0  0
up      8    3  000  0  0
dn      4    3  009  0  0
rel     1    7  3ff  f  f
wait    400  7  3ff  f  f
fire    2    2  024  f  f
fire    1    3  024  f  f
dn      14   3  047  f  f
rel     1    7  3ff  f  f
wait    400  7  3ff  f  f
match   400  5  3ff  f  f
fire    2    2  024  0  0

// File: tb/pong_tb.sv
// pong testbench: raster timing monitor, pixel compare against a game model
// scenarios read from the stimulus file, scores and paddle rows checked per line

`timescale 1ns/1ns

module pong_tb import video_pkg::*, game_pkg::*; ();

    localparam int H_RES = 160, V_RES = 120;
    localparam int H_FP = 4, H_SYNC = 8, H_BP = 4, V_FP = 2, V_SYNC = 2, V_BP = 2;
    localparam int BALL = 8, PAD_H = 48, PAD_W = 10, PAD_OFFS = 32, PAD_SPY = 3;
    localparam int ISPX = 5, ISPY = 3, WIN = 2, SPEEDUP = 5, DEB_BITS = 3;
    localparam int H_TOT = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOT = V_RES + V_FP + V_SYNC + V_BP;
    localparam int PAD_MAX = V_RES - PAD_H - 1;           // lowest paddle top row
    localparam int PAD_MID = (V_RES - PAD_H) / 2;
    localparam int PAD_R_X = H_RES - PAD_OFFS - PAD_W;
    localparam int DIG_L_X = H_RES / 2 - 32, DIG_R_X = H_RES / 2 + 8, DIG_Y = 8;

    logic   clk_pix = 1'b0, rst_n = 1'b0;
    logic   btn_up = 1'b0, btn_dn = 1'b0, btn_fire = 1'b0;
    rgb_t   rgb;
    logic   hsync, vsync, de;
    score_t score_l, score_r;

    game_state_t m_state;                          // reference game model
    int bx, by, bdx, bdy, spx, spy, shots, ly, ry, sl, sr, last_r;
    int hold_up = 0, hold_dn = 0;
    int ox = 0, oy = 0, frame_no = 0, pad_cur, pad_last = 'h3ff;
    logic pad_seen = 1'b0, pix_on = 1'b0, running = 1'b0;
    longint cycles = 0, limit = 0;
    logic [47:0] sc_act [32];                      // scenario table
    int sc_frames [32], sc_st [32], sc_pad [32], sc_sl [32], sc_sr [32], sc_count = 0;

    pong_top #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP), .BALL_SIZE(BALL), .PAD_HEIGHT(PAD_H),
        .PAD_WIDTH(PAD_W), .PAD_OFFS(PAD_OFFS), .PAD_SPY(PAD_SPY), .BALL_ISPX(ISPX),
        .BALL_ISPY(ISPY), .WIN(WIN), .SPEEDUP(SPEEDUP), .DEB_BITS(DEB_BITS)
    ) UUT (
        .clk_pix, .rst_n, .btn_up, .btn_dn, .btn_fire, .rgb, .hsync, .vsync, .de,
        .score_l, .score_r
    );

    always #4 clk_pix = ~clk_pix;  // 8 ns period

    task automatic report_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [11:0] got, input logic [11:0] exp);
        assert (got === exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    function automatic logic [14:0] digit_rows(int d);
        case (d)  // 3x5 glyph with top row first
            0: return 15'b111_101_101_101_111;
            1: return 15'b010_110_010_010_111;
            2: return 15'b111_001_111_100_111;
            3: return 15'b111_001_111_001_111;
            4: return 15'b101_101_111_001_001;
            default: return '0;
        endcase
    endfunction

    function automatic logic in_digit(int d, int x, int y, int x0);
        logic [14:0] rows;
        if (x < x0 || x >= x0 + 24 || y < DIG_Y || y >= DIG_Y + 40) return 1'b0;
        rows = digit_rows(d);
        return rows[14 - ((y - DIG_Y) / 8) * 3 - (x - x0) / 8];  // cells of 8x8
    endfunction

    function automatic rgb_t exp_colour(int x, int y);
        if (in_digit(sl, x, y, DIG_L_X) || in_digit(sr, x, y, DIG_R_X)) return 12'hF30;
        if (x >= bx && x < bx + BALL && y >= by && y < by + BALL) return 12'hFC0;
        if ((x >= PAD_OFFS && x < PAD_OFFS + PAD_W && y >= ly && y < ly + PAD_H)
            || (x >= PAD_R_X && x < PAD_R_X + PAD_W && y >= ry && y < ry + PAD_H))
            return 12'hFFF;
        return 12'h137;  // background
    endfunction

    function automatic int pad_down(int y);
        return (y + PAD_SPY >= PAD_MAX) ? PAD_MAX : y + PAD_SPY;
    endfunction

    function automatic int pad_up(int y);
        return (y < PAD_SPY) ? 0 : y - PAD_SPY;
    endfunction

    task automatic serve_ball();
        bx    = last_r ? PAD_R_X - BALL : PAD_OFFS + PAD_W;  // beside the scoring side
        bdx   = last_r;
        by    = (V_RES - BALL) / 2;
        spx   = ISPX;
        spy   = ISPY;
        shots = 0;
        ly    = PAD_MID;
        ry    = PAD_MID;
    endtask

    task automatic apply_fire();
        case (m_state)
            READY: m_state = PLAY;
            POINT: begin
                serve_ball();
                m_state = READY;
            end
            END_GAME: begin
                sl = 0;
                sr = 0;
                last_r = 0;
                serve_ball();
                m_state = READY;
            end
            default: ;  // fire ignored in play
        endcase
    endtask

    // one frame of play on the old ball and paddles
    task automatic step_model();
        int hl, hr, ndx, nly, nry, wall;
        hl  = bdx && bx < PAD_OFFS + PAD_W && bx + BALL > PAD_OFFS
              && by + BALL > ly && by < ly + PAD_H;
        hr  = !bdx && bx + BALL > PAD_R_X && bx < PAD_R_X + PAD_W
              && by + BALL > ry && by < ry + PAD_H;
        ndx = bdx ^ (hl || hr);
        nly = hold_up ? pad_up(ly) : (hold_dn ? pad_down(ly) : ly);  // up wins
        nry = ry;
        if (ry + PAD_H / 2 < by) nry = pad_down(ry);
        else if (ry + PAD_H / 2 > by + BALL) nry = pad_up(ry);
        wall = 0;
        if (!ndx) begin
            if (bx + BALL + spx >= H_RES - 1) begin  // right wall
                bx = H_RES - BALL;
                sl++;
                last_r = 1;
                wall = 1;
            end else bx = bx + spx;
        end else if (bx < spx) begin  // left wall
            bx = 0;
            sr++;
            last_r = 0;
            wall = 1;
        end else bx = bx - spx;
        bdx = ndx;
        if (!bdy) begin
            if (by + BALL + spy >= V_RES - 1) bdy = 1;
            else by = by + spy;
        end else if (by < spy) bdy = 0;
        else by = by - spy;
        if (hl || hr) begin  // shot counting with new speeds next frame
            if (shots == SPEEDUP - 1) begin
                shots = 0;
                if (spx < PAD_W) spx++;
                if (spy < 15) spy++;
            end else shots++;
        end
        ly = nly;
        ry = nry;
        if (wall) m_state = (sl == WIN || sr == WIN) ? END_GAME : POINT;
    endtask

    task automatic end_of_frame();
        if (pix_on) check_value("game_state", UUT.u_game.game_state, m_state);
        if (m_state == PLAY) step_model();
        if (pix_on) begin
            check_value("score_l", score_l, sl);
            check_value("score_r", score_r, sr);
        end
        pad_last = pad_seen ? pad_cur : 'h3ff;  // top row of the frame just drawn
        pad_seen = 1'b0;
        frame_no++;
        pix_on = 1'b1;
    endtask

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (rst_n) running <= 1'b1;  // outputs show pixel 0,0 from here
        if (limit > 0 && cycles > limit) begin
            $display("timeout, the scenarios did not finish within %0d cycles", limit);
            report_failure();
        end
    end

    // raster monitor sampling outputs mid cycle
    always @(negedge clk_pix) begin
        if (!rst_n && cycles > 2) begin
            check_value("hsync", hsync, 1'b1);
            check_value("vsync", vsync, 1'b1);
            check_value("de", de, 1'b0);
            check_value("rgb", rgb, 12'h000);
        end else if (running) begin
            check_value("de", de, ox < H_RES && oy < V_RES);
            check_value("hsync", hsync, !(ox >= H_RES + H_FP && ox < H_RES + H_FP + H_SYNC));
            check_value("vsync", vsync, !(oy >= V_RES + V_FP && oy < V_RES + V_FP + V_SYNC));
            if (!(ox < H_RES && oy < V_RES)) check_value("rgb", rgb, 12'h000);
            else if (pix_on) check_value("rgb", rgb, exp_colour(ox, oy));
            if (ox == PAD_OFFS && oy < V_RES && rgb == 12'hFFF && !pad_seen) begin
                pad_cur  = oy;
                pad_seen = 1'b1;
            end
            if (ox == 0 && oy == V_RES) end_of_frame();  // strobe already taken
            ox = (ox == H_TOT - 1) ? 0 : ox + 1;
            if (ox == 0) oy = (oy == V_TOT - 1) ? 0 : oy + 1;
        end
    end

    task automatic wait_frames(int n);
        int target;
        target = frame_no + n;
        while (frame_no < target) @(negedge clk_pix);
    endtask

    task automatic press_fire();
        @(negedge clk_pix);
        btn_fire = 1'b1;
        apply_fire();
        repeat (20) @(negedge clk_pix);  // well past the debounce window
        btn_fire = 1'b0;
    endtask

    task automatic wait_point(int max_frames);
        int n;
        n = 0;
        while (m_state == PLAY) begin
            if (n >= max_frames) begin
                $display("point did not end within %0d frames", max_frames);
                report_failure();
            end
            wait_frames(1);
            n++;
        end
        wait_frames(1);  // state register settles
    endtask

    task automatic load_scenarios();
        int fd, n;
        string line;
        logic [47:0] act;
        int fr, st, pad, s_l, s_r;
        fd = $fopen("tb/pong_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            report_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%s %d %h %h %h %h", act, fr, st, pad, s_l, s_r);
            if (n != 6) continue;
            sc_act[sc_count] = act;
            sc_frames[sc_count] = fr;
            sc_st[sc_count] = st;
            sc_pad[sc_count] = pad;
            sc_sl[sc_count] = s_l;
            sc_sr[sc_count] = s_r;
            limit += (act == "match") ? fr * (2 * WIN) + 4 * WIN : fr + 2;
            sc_count++;
        end
        $fclose(fd);
        limit = (limit + 10) * H_TOT * V_TOT;  // frames to cycles plus margin
    endtask

    task automatic run_line(int i);
        case (sc_act[i])
            "fire": press_fire();
            "up": begin
                btn_up  = 1'b1;
                btn_dn  = 1'b0;
                hold_up = 1;
                hold_dn = 0;
            end
            "dn": begin
                btn_up  = 1'b0;
                btn_dn  = 1'b1;
                hold_up = 0;
                hold_dn = 1;
            end
            "rel": begin
                btn_up  = 1'b0;
                btn_dn  = 1'b0;
                hold_up = 0;
                hold_dn = 0;
            end
            "glitch": repeat (3) begin  // pulses shorter than the window
                btn_fire = 1'b1;
                repeat (3) @(negedge clk_pix);
                btn_fire = 1'b0;
                repeat (3) @(negedge clk_pix);
            end
            default: ;
        endcase
        if (sc_act[i] == "wait") wait_point(sc_frames[i]);
        else if (sc_act[i] == "match") begin
            while (m_state != END_GAME) begin
                if (m_state == PLAY) wait_point(sc_frames[i]);
                else begin
                    press_fire();
                    wait_frames(1);
                end
            end
            wait_frames(1);
        end else wait_frames(sc_frames[i]);
        if (sc_st[i] != 7) check_value("game_state", UUT.u_game.game_state, sc_st[i]);
        if (sc_pad[i] != 'h3ff) check_value("left_paddle_row", pad_last, sc_pad[i]);
        if (sc_sl[i] != 'hf) check_value("score_l", score_l, sc_sl[i]);
        if (sc_sr[i] != 'hf) check_value("score_r", score_r, sc_sr[i]);
    endtask

    initial begin
        load_scenarios();
        m_state = READY;  // NEW_GAME and POSITION pass within two cycles
        sl = 0;
        sr = 0;
        last_r = 0;
        bdy = 0;
        serve_ball();
        repeat (16) @(posedge clk_pix);
        @(negedge clk_pix);
        rst_n = 1'b1;
        for (int i = 0; i < sc_count; i++) run_line(i);
        if (sc_count > 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("no scenario lines were run");
            report_failure();
        end
    end

endmodule

// File: logic/pong_top.sv
// pong top level: buttons, display timing, paddles, game and renderer
// ends at parallel rgb with syncs and de, scores also exported

`timescale 1ns/1ns

module pong_top import video_pkg::*, game_pkg::*; #(
    parameter int H_RES      = 640,
    parameter int V_RES      = 480,
    parameter int H_FP       = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BP       = 48,
    parameter int V_FP       = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BP       = 33,
    parameter int BALL_SIZE  = 8,
    parameter int PAD_HEIGHT = 48,
    parameter int PAD_WIDTH  = 10,
    parameter int PAD_OFFS   = 32,
    parameter int PAD_SPY    = 3,
    parameter int BALL_ISPX  = 5,
    parameter int BALL_ISPY  = 3,
    parameter int WIN        = 4,   // at most 9
    parameter int SPEEDUP    = 5,   // shots per speed-up
    parameter int DEB_BITS   = 16
) (
    input  logic   clk_pix,
    input  logic   rst_n,
    input  logic   btn_up,
    input  logic   btn_dn,
    input  logic   btn_fire,
    output rgb_t   rgb,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output score_t score_l,
    output score_t score_r
);

    buttons_t    buttons;
    raster_t     raster;
    logic        frame;  // start of vertical blanking
    game_state_t game_state;
    ball_t       ball;
    paddles_t    paddles;

    btn_debounce #(.DEB_BITS(DEB_BITS)) u_debounce (
        .clk_pix, .rst_n, .btn_up, .btn_dn, .btn_fire, .buttons
    );

    raster_timing #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_timing (
        .clk_pix, .rst_n, .raster, .frame
    );

    paddle_ctrl #(
        .V_RES(V_RES), .PAD_HEIGHT(PAD_HEIGHT), .PAD_SPY(PAD_SPY), .BALL_SIZE(BALL_SIZE)
    ) u_paddles (
        .clk_pix, .rst_n, .frame, .game_state, .ball, .buttons, .paddles
    );

    game_core #(
        .H_RES(H_RES), .V_RES(V_RES), .BALL_SIZE(BALL_SIZE), .BALL_ISPX(BALL_ISPX),
        .BALL_ISPY(BALL_ISPY), .PAD_HEIGHT(PAD_HEIGHT), .PAD_WIDTH(PAD_WIDTH),
        .PAD_OFFS(PAD_OFFS), .WIN(WIN), .SPEEDUP(SPEEDUP)
    ) u_game (
        .clk_pix, .rst_n, .frame, .buttons, .paddles, .game_state, .ball, .score_l, .score_r
    );

    frame_render #(
        .H_RES(H_RES), .BALL_SIZE(BALL_SIZE), .PAD_HEIGHT(PAD_HEIGHT),
        .PAD_WIDTH(PAD_WIDTH), .PAD_OFFS(PAD_OFFS)
    ) u_render (
        .clk_pix, .rst_n, .raster, .ball, .paddles, .score_l, .score_r,
        .rgb, .hsync, .vsync, .de
    );

endmodule

// File: logic/frame_render.sv
// pixel painter: ball, paddles and 3x5 score digits scaled by 8
// colour, syncs and de leave through one output register stage

`timescale 1ns/1ns

module frame_render import video_pkg::*, game_pkg::*; #(
    parameter int H_RES      = 640,
    parameter int BALL_SIZE  = 8,
    parameter int PAD_HEIGHT = 48,
    parameter int PAD_WIDTH  = 10,
    parameter int PAD_OFFS   = 32
) (
    input  logic     clk_pix,
    input  logic     rst_n,
    input  raster_t  raster,
    input  ball_t    ball,
    input  paddles_t paddles,
    input  score_t   score_l,
    input  score_t   score_r,
    output rgb_t     rgb,
    output logic     hsync,
    output logic     vsync,
    output logic     de
);

    localparam int PAD_R_X = H_RES - PAD_OFFS - PAD_WIDTH;
    localparam int DIG_W   = 3 * 8;               // scaled glyph width
    localparam int DIG_H   = 5 * 8;
    localparam int DIG_Y   = 8;                   // top of both digits
    localparam int DIG_L_X = H_RES / 2 - DIG_W - 8;
    localparam int DIG_R_X = H_RES / 2 + 8;

    function automatic logic [14:0] glyph(score_t d);
        case (d)  // rows top to bottom, left column first
            4'd0:    return 15'b111_101_101_101_111;
            4'd1:    return 15'b010_110_010_010_111;
            4'd2:    return 15'b111_001_111_100_111;
            4'd3:    return 15'b111_001_111_001_111;
            4'd4:    return 15'b101_101_111_001_001;
            4'd5:    return 15'b111_100_111_001_111;
            4'd6:    return 15'b111_100_111_101_111;
            4'd7:    return 15'b111_001_001_001_001;
            4'd8:    return 15'b111_101_111_101_111;
            4'd9:    return 15'b111_101_111_001_111;
            default: return '0;
        endcase
    endfunction

    function automatic logic digit_pix(score_t d, coord_t px, coord_t py, int x0);
        logic [14:0] g;
        int          col, row;
        if (px < x0 || px >= x0 + DIG_W || py < DIG_Y || py >= DIG_Y + DIG_H) return 1'b0;
        g   = glyph(d);
        col = (px - x0) / 8;     // glyph cell
        row = (py - DIG_Y) / 8;
        return g[14 - row * 3 - col];
    endfunction

    logic in_score, in_ball, in_pad;
    rgb_t colour;

    always_comb begin
        in_score = digit_pix(score_l, raster.sx, raster.sy, DIG_L_X)
                || digit_pix(score_r, raster.sx, raster.sy, DIG_R_X);
        in_ball  = (raster.sx >= ball.x) && (raster.sx < ball.x + BALL_SIZE)
                && (raster.sy >= ball.y) && (raster.sy < ball.y + BALL_SIZE);
        in_pad   = ((raster.sx >= PAD_OFFS) && (raster.sx < PAD_OFFS + PAD_WIDTH)
                    && (raster.sy >= paddles.left_y)
                    && (raster.sy < paddles.left_y + PAD_HEIGHT))
                || ((raster.sx >= PAD_R_X) && (raster.sx < PAD_R_X + PAD_WIDTH)
                    && (raster.sy >= paddles.right_y)
                    && (raster.sy < paddles.right_y + PAD_HEIGHT));
        if (!raster.de) colour = COL_BLANK;
        else if (in_score) colour = COL_SCORE;  // score drawn on top
        else if (in_ball) colour = COL_BALL;
        else if (in_pad) colour = COL_PAD;
        else colour = COL_BACK;
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            rgb   <= COL_BLANK;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            rgb   <= colour;
            hsync <= raster.hsync;  // kept aligned with colour
            vsync <= raster.vsync;
            de    <= raster.de;
        end
    end

endmodule

// File: logic/game_core.sv
// game FSM, ball motion and bounces, shot counting and speed-up, scores
// paddle hits are tested on the ball and paddle boxes once per frame

`timescale 1ns/1ns

module game_core import video_pkg::*, game_pkg::*; #(
    parameter int H_RES      = 640,
    parameter int V_RES      = 480,
    parameter int BALL_SIZE  = 8,
    parameter int BALL_ISPX  = 5,
    parameter int BALL_ISPY  = 3,
    parameter int PAD_HEIGHT = 48,
    parameter int PAD_WIDTH  = 10,
    parameter int PAD_OFFS   = 32,
    parameter int WIN        = 4,
    parameter int SPEEDUP    = 5
) (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        frame,
    input  buttons_t    buttons,
    input  paddles_t    paddles,
    output game_state_t game_state,
    output ball_t       ball,
    output score_t      score_l,
    output score_t      score_r
);

    localparam int PAD_R_X = H_RES - PAD_OFFS - PAD_WIDTH;  // right paddle left edge

    game_state_t state_next;
    logic        coll_l, coll_r;  // side wall reached
    logic [3:0]  shot_cnt;        // reversals since last speed-up
    logic        hit_l, hit_r;    // paddle overlap in direction of travel
    logic        dx_n;            // direction after this frame's bounce

    always_comb begin
        hit_l = ball.dx
            && (ball.x < PAD_OFFS + PAD_WIDTH) && (ball.x + BALL_SIZE > PAD_OFFS)
            && (ball.y + BALL_SIZE > paddles.left_y) && (ball.y < paddles.left_y + PAD_HEIGHT);
        hit_r = !ball.dx
            && (ball.x + BALL_SIZE > PAD_R_X) && (ball.x < PAD_R_X + PAD_WIDTH)
            && (ball.y + BALL_SIZE > paddles.right_y) && (ball.y < paddles.right_y + PAD_HEIGHT);
        dx_n = ball.dx ^ (hit_l || hit_r);
    end

    always_comb begin
        state_next = game_state;
        case (game_state)
            NEW_GAME: state_next = POSITION;
            POSITION: state_next = READY;
            READY:    if (buttons.fire) state_next = PLAY;
            PLAY: begin
                if (coll_l || coll_r)  // scores already updated
                    state_next = (score_l == WIN || score_r == WIN) ? END_GAME : POINT;
            end
            POINT:    if (buttons.fire) state_next = POSITION;
            END_GAME: if (buttons.fire) state_next = NEW_GAME;
            default:  state_next = NEW_GAME;
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) game_state <= NEW_GAME;
        else game_state <= state_next;
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            score_l  <= '0;
            score_r  <= '0;
            coll_l   <= 1'b0;
            coll_r   <= 1'b0;
            shot_cnt <= '0;
            ball.dx  <= 1'b0;
            ball.dy  <= 1'b0;
        end else begin
            case (game_state)
                NEW_GAME: begin
                    score_l <= '0;
                    score_r <= '0;
                    coll_l  <= 1'b0;  // first serve from the left
                    coll_r  <= 1'b0;
                end
                POSITION: begin
                    coll_l   <= 1'b0;
                    coll_r   <= 1'b0;
                    shot_cnt <= '0;
                    ball.spx <= speed_t'(BALL_ISPX);
                    ball.spy <= speed_t'(BALL_ISPY);
                    ball.y   <= coord_t'((V_RES - BALL_SIZE) / 2);
                    if (coll_r) begin  // serve from beside the right paddle
                        ball.x  <= coord_t'(PAD_R_X - BALL_SIZE);
                        ball.dx <= 1'b1;
                    end else begin
                        ball.x  <= coord_t'(PAD_OFFS + PAD_WIDTH);
                        ball.dx <= 1'b0;
                    end
                end
                PLAY: begin
                    if (frame) begin
                        ball.dx <= dx_n;
                        if (hit_l || hit_r) begin
                            if (shot_cnt == SPEEDUP - 1) begin  // speed-up due
                                shot_cnt <= '0;
                                if (ball.spx < PAD_WIDTH) ball.spx <= ball.spx + 1'b1;
                                if (ball.spy != '1) ball.spy <= ball.spy + 1'b1;
                            end else begin
                                shot_cnt <= shot_cnt + 1'b1;
                            end
                        end
                        if (!dx_n) begin  // moving right
                            if (ball.x + BALL_SIZE + ball.spx >= H_RES - 1) begin
                                ball.x  <= coord_t'(H_RES - BALL_SIZE);
                                score_l <= score_l + 1'b1;
                                coll_r  <= 1'b1;
                            end else ball.x <= ball.x + ball.spx;
                        end else begin
                            if (ball.x < ball.spx) begin  // left wall
                                ball.x  <= '0;
                                score_r <= score_r + 1'b1;
                                coll_l  <= 1'b1;
                            end else ball.x <= ball.x - ball.spx;
                        end
                        if (!ball.dy) begin  // moving down
                            if (ball.y + BALL_SIZE + ball.spy >= V_RES - 1) ball.dy <= 1'b1;
                            else ball.y <= ball.y + ball.spy;
                        end else begin
                            if (ball.y < ball.spy) ball.dy <= 1'b0;
                            else ball.y <= ball.y - ball.spy;
                        end
                    end
                end
                default: ;  // waiting for fire
            endcase
        end
    end

    assert property (@(posedge clk_pix) disable iff (!rst_n)
        (score_l <= WIN) && (score_r <= WIN));

endmodule

// File: logic/paddle_ctrl.sv
// paddle motion, once per frame while playing
// left paddle follows the buttons, right paddle tracks the ball

`timescale 1ns/1ns

module paddle_ctrl import video_pkg::*, game_pkg::*; #(
    parameter int V_RES      = 480,
    parameter int PAD_HEIGHT = 48,
    parameter int PAD_SPY    = 3,
    parameter int BALL_SIZE  = 8
) (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        frame,
    input  game_state_t game_state,
    input  ball_t       ball,
    input  buttons_t    buttons,
    output paddles_t    paddles
);

    localparam int PAD_MAX = V_RES - PAD_HEIGHT - 1;  // lowest top row
    localparam int PAD_MID = (V_RES - PAD_HEIGHT) / 2;

    function automatic coord_t move_dn(coord_t y);
        if (y + PAD_SPY >= PAD_MAX) return coord_t'(PAD_MAX);  // clamp at bottom
        return coord_t'(y + PAD_SPY);
    endfunction

    function automatic coord_t move_up(coord_t y);
        if (y < PAD_SPY) return '0;  // clamp at top
        return coord_t'(y - PAD_SPY);
    endfunction

    logic play_frame;

    always_comb play_frame = frame && (game_state == PLAY);

    always_ff @(posedge clk_pix) begin
        if (!rst_n || game_state == POSITION) begin
            paddles.left_y  <= coord_t'(PAD_MID);
            paddles.right_y <= coord_t'(PAD_MID);
        end else if (play_frame) begin
            if (buttons.up) paddles.left_y <= move_up(paddles.left_y);  // up wins
            else if (buttons.dn) paddles.left_y <= move_dn(paddles.left_y);
            if (paddles.right_y + PAD_HEIGHT / 2 < ball.y)  // ball lower
                paddles.right_y <= move_dn(paddles.right_y);
            else if (paddles.right_y + PAD_HEIGHT / 2 > ball.y + BALL_SIZE)
                paddles.right_y <= move_up(paddles.right_y);
        end
    end

    assert property (@(posedge clk_pix) disable iff (!rst_n)
        (paddles.left_y + PAD_HEIGHT <= V_RES) && (paddles.right_y + PAD_HEIGHT <= V_RES));

endmodule

// File: logic/raster_timing.sv
// display timing generator
// pixel counters, active-low syncs, data enable and the frame strobe

`timescale 1ns/1ns

module raster_timing import video_pkg::*; #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic    clk_pix,
    input  logic    rst_n,
    output raster_t raster,
    output logic    frame
);

    localparam int HS_STA  = H_RES + H_FP;     // first hsync cycle
    localparam int HS_END  = HS_STA + H_SYNC;  // first cycle after hsync
    localparam int H_TOTAL = HS_END + H_BP;
    localparam int VS_STA  = V_RES + V_FP;
    localparam int VS_END  = VS_STA + V_SYNC;
    localparam int V_TOTAL = VS_END + V_BP;

    coord_t sx, sy;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_TOTAL - 1) begin  // end of line
            sx <= '0;
            sy <= (sy == V_TOTAL - 1) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        raster.sx    = sx;
        raster.sy    = sy;
        raster.de    = (sx < H_RES) && (sy < V_RES);
        raster.hsync = !((sx >= HS_STA) && (sx < HS_END));  // low in pulse
        raster.vsync = !((sy >= VS_STA) && (sy < VS_END));
        frame        = (sy == V_RES) && (sx == 0);  // first blanking line
    end

    // counter stays inside the line
    assert property (@(posedge clk_pix) disable iff (!rst_n) sx < H_TOTAL);

endmodule

// File: logic/btn_debounce.sv
// button input stage
// two-flop synchroniser and stability counter per button, fire press pulse

`timescale 1ns/1ns

module btn_debounce import game_pkg::*; #(
    parameter int DEB_BITS = 16  // stable for 2**DEB_BITS cycles
) (
    input  logic     clk_pix,
    input  logic     rst_n,
    input  logic     btn_up,
    input  logic     btn_dn,
    input  logic     btn_fire,
    output buttons_t buttons
);

    logic [2:0]          sync_a, sync_b;  // synchroniser stages, {fire, dn, up}
    logic [2:0]          level;           // accepted levels
    logic                fire_q;          // accepted fire, one cycle late
    logic [DEB_BITS-1:0] cnt [3];         // stability counters

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sync_a <= '0;
            sync_b <= '0;
            level  <= '0;
            fire_q <= 1'b0;
            for (int i = 0; i < 3; i++) cnt[i] <= '0;
        end else begin
            sync_a <= {btn_fire, btn_dn, btn_up};
            sync_b <= sync_a;
            fire_q <= level[2];
            for (int i = 0; i < 3; i++) begin
                if (sync_b[i] == level[i]) begin
                    cnt[i] <= '0;  // no change pending, restart
                end else if (&cnt[i]) begin
                    level[i] <= sync_b[i];  // stable long enough
                    cnt[i]   <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        buttons.up   = level[0];
        buttons.dn   = level[1];
        buttons.fire = level[2] && !fire_q;  // rising edge of accepted fire
    end

endmodule

// File: logic/game_pkg.sv
// game types: state enum, score digit, buttons, ball and paddles
// builds on the coordinate type of the video package

package game_pkg;

    import video_pkg::*;

    typedef enum logic [2:0] {
        NEW_GAME,
        POSITION,
        READY,
        PLAY,
        POINT,
        END_GAME
    } game_state_t;

    typedef logic [3:0] score_t;  // one decimal digit
    typedef logic [3:0] speed_t;  // pixels per frame

    typedef struct packed {
        logic up;    // held level
        logic dn;    // held level
        logic fire;  // one-cycle press pulse
    } buttons_t;

    typedef struct packed {
        coord_t x;    // top left corner
        coord_t y;
        logic   dx;   // 0 is right
        logic   dy;   // 0 is down
        speed_t spx;
        speed_t spy;
    } ball_t;

    typedef struct packed {
        coord_t left_y;   // player paddle top row
        coord_t right_y;  // automatic paddle top row
    } paddles_t;

endpackage

// File: logic/video_pkg.sv
// raster and colour types for display timing, renderer and game
// also holds the fixed palette of the game

package video_pkg;

    typedef logic [9:0]  coord_t;  // screen coordinate
    typedef logic [11:0] rgb_t;    // 4 bits each of r, g, b

    typedef struct packed {
        coord_t sx;     // horizontal position
        coord_t sy;     // vertical position
        logic   de;     // visible area
        logic   hsync;  // active low
        logic   vsync;  // active low
    } raster_t;

    // palette
    localparam rgb_t COL_SCORE = 12'hF30;  // score digits
    localparam rgb_t COL_BALL  = 12'hFC0;  // ball
    localparam rgb_t COL_PAD   = 12'hFFF;  // both paddles
    localparam rgb_t COL_BACK  = 12'h137;  // background
    localparam rgb_t COL_BLANK = 12'h000;  // blanking

endpackage
